//--- hw/addr_types_pkg.sv
`default_nettype none

package addr_types_pkg;

   // Memory side widths
   localparam int ADDR_W   = 10;
   localparam int PERIOD_W = 10;
   localparam int DELAY_W  = 7;

   // Databus side widths
   localparam int AXI_ADDR_W = 32;
   localparam int LEN_W      = 8;
   localparam int COUNT_W    = 8;

   // Memory word size in bits and the matching byte shift
   localparam int DATA_W   = 32;
   localparam int OFFSET_W = $clog2(DATA_W / 8);

   typedef logic        [ADDR_W-1:0]     addr_t;
   typedef logic signed [ADDR_W-1:0]     step_t;
   typedef logic        [PERIOD_W-1:0]   period_t;
   typedef logic        [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic        [LEN_W-1:0]      len_t;
   typedef logic        [COUNT_W-1:0]    count_t;

endpackage

`default_nettype wire

//--- hw/addr_ctrl_pkg.sv
`default_nettype none

package addr_ctrl_pkg;

   // Which loop counter moves on an accepted address
   typedef enum logic [2:0] {
      STEP_PER   = 3'd0,
      STEP_ITER  = 3'd1,
      STEP_PER2  = 3'd2,
      STEP_ITER2 = 3'd3,
      STEP_PER3  = 3'd4,
      STEP_ITER3 = 3'd5,
      STEP_DONE  = 3'd6
   } loop_step_e;

   // Databus burst controller states
   typedef enum logic [1:0] {
      BUS_IDLE  = 2'd0,
      BUS_SETUP = 2'd1,
      BUS_BURST = 2'd2
   } bus_state_e;

endpackage

`default_nettype wire

//--- hw/loop_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface loop_cfg_if;
   import addr_types_pkg::*;

   addr_t                start;
   period_t              duty;
   logic [DELAY_W-1:0]   delay;

   // Level 1
   period_t period;
   step_t   incr;
   addr_t   iterations;
   step_t   shift;

   // Level 2
   period_t period2;
   step_t   incr2;
   addr_t   iterations2;
   step_t   shift2;

   // Level 3
   period_t period3;
   step_t   incr3;
   addr_t   iterations3;
   step_t   shift3;

   modport src (
      output start, duty, delay,
      output period, incr, iterations, shift,
      output period2, incr2, iterations2, shift2,
      output period3, incr3, iterations3, shift3
   );

   modport dst (
      input start, duty, delay,
      input period, incr, iterations, shift,
      input period2, incr2, iterations2, shift2,
      input period3, incr3, iterations3, shift3
   );

endinterface

`default_nettype wire

//--- hw/count_n_loops.sv
`timescale 1ns/10ps
`default_nettype none

module count_n_loops (
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire                    start_i,
   input  addr_types_pkg::count_t count_i,
   input  wire                    advance_i,
   output logic                   count_is_zero_o
);
   import addr_types_pkg::*;

   // Bursts left after the one in flight
   count_t remaining_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         remaining_q <= '0;
      end else if (start_i) begin
         remaining_q <= count_i - 1'b1;
      end else if (advance_i && (remaining_q != '0)) begin
         remaining_q <= remaining_q - 1'b1;
      end
   end

   assign count_is_zero_o = (remaining_q == '0);

endmodule

`default_nettype wire

//--- hw/loop_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module loop_addr_gen (
   input  wire                   clk_i,
   input  wire                   rst_i,
   input  wire                   run_i,
   input  wire                   ignore_first_i,
   loop_cfg_if.dst               cfg,
   output logic                  valid_o,
   input  wire                   ready_i,
   output addr_types_pkg::addr_t addr_o,
   output logic                  store_o,
   output logic                  done_o
);
   import addr_types_pkg::*;
   import addr_ctrl_pkg::*;

   logic [DELAY_W-1:0] delay_q;
   period_t            per_q;
   period_t            per2_q;
   period_t            per3_q;
   addr_t              iter_q;
   addr_t              iter2_q;
   addr_t              iter3_q;
   addr_t              base2_q;
   addr_t              base3_q;
   logic               skip_q;

   logic       per_done;
   logic       iter_done;
   logic       per2_done;
   logic       iter2_done;
   logic       per3_done;
   logic       iter3_done;
   loop_step_e step;
   addr_t      start_addr;
   addr_t      lvl2_next;
   addr_t      lvl3_next;

   // Word step to byte step
   function automatic addr_t scale(input step_t s);
      return addr_t'(s) << OFFSET_W;
   endfunction

   // A limit of zero counts as already complete
   assign per_done   = (period_t'(per_q + 1'b1) == cfg.period) || (cfg.period == '0);
   assign iter_done  = (addr_t'(iter_q + 1'b1) == cfg.iterations) || (cfg.iterations == '0);
   assign per2_done  = (period_t'(per2_q + 1'b1) == cfg.period2) || (cfg.period2 == '0);
   assign iter2_done = (addr_t'(iter2_q + 1'b1) == cfg.iterations2) || (cfg.iterations2 == '0);
   assign per3_done  = (period_t'(per3_q + 1'b1) == cfg.period3) || (cfg.period3 == '0);
   assign iter3_done = (addr_t'(iter3_q + 1'b1) == cfg.iterations3) || (cfg.iterations3 == '0);

   // Innermost incomplete level wins
   always_comb begin
      if (!per_done) begin
         step = STEP_PER;
      end else if (!iter_done) begin
         step = STEP_ITER;
      end else if (!per2_done) begin
         step = STEP_PER2;
      end else if (!iter2_done) begin
         step = STEP_ITER2;
      end else if (!per3_done) begin
         step = STEP_PER3;
      end else if (!iter3_done) begin
         step = STEP_ITER3;
      end else begin
         step = STEP_DONE;
      end
   end

   assign start_addr = cfg.start << OFFSET_W;
   assign lvl2_next  = base2_q + scale((step == STEP_PER2) ? cfg.incr2 : cfg.shift2);
   assign lvl3_next  = base3_q + scale((step == STEP_PER3) ? cfg.incr3 : cfg.shift3);

   assign store_o = (per_q < cfg.duty) && !skip_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         delay_q <= '0;
         addr_o  <= '0;
         base2_q <= '0;
         base3_q <= '0;
         per_q   <= '0;
         per2_q  <= '0;
         per3_q  <= '0;
         iter_q  <= '0;
         iter2_q <= '0;
         iter3_q <= '0;
         skip_q  <= 1'b1;
         valid_o <= 1'b0;
         done_o  <= 1'b1;
      end else if (run_i) begin
         delay_q <= cfg.delay;
         addr_o  <= start_addr;
         base2_q <= start_addr;
         base3_q <= start_addr;
         per_q   <= '0;
         per2_q  <= '0;
         per3_q  <= '0;
         iter_q  <= '0;
         iter2_q <= '0;
         iter3_q <= '0;
         skip_q  <= ignore_first_i;
         valid_o <= (cfg.delay == '0);
         done_o  <= 1'b0;
      end else if (delay_q != '0) begin
         // Valid comes up as the count leaves 1
         delay_q <= delay_q - 1'b1;
         valid_o <= (delay_q == 1);
      end else if (valid_o && ready_i) begin
         case (step)
            STEP_PER: begin
               if (store_o) begin
                  addr_o <= addr_o + scale(cfg.incr);
               end
               per_q <= per_q + 1'b1;
            end
            STEP_ITER: begin
               if (!skip_q) begin
                  addr_o <= addr_o + scale(cfg.shift);
               end
               per_q  <= '0;
               iter_q <= iter_q + 1'b1;
               skip_q <= 1'b0;
            end
            STEP_PER2, STEP_ITER2: begin
               if (!skip_q) begin
                  addr_o  <= lvl2_next;
                  base2_q <= lvl2_next;
               end
               per_q  <= '0;
               iter_q <= '0;
               if (step == STEP_PER2) begin
                  per2_q <= per2_q + 1'b1;
               end else begin
                  per2_q  <= '0;
                  iter2_q <= iter2_q + 1'b1;
               end
               skip_q <= 1'b0;
            end
            STEP_PER3, STEP_ITER3: begin
               // Level 3 move also rebases level 2
               if (!skip_q) begin
                  addr_o  <= lvl3_next;
                  base2_q <= lvl3_next;
                  base3_q <= lvl3_next;
               end
               per_q   <= '0;
               iter_q  <= '0;
               per2_q  <= '0;
               iter2_q <= '0;
               if (step == STEP_PER3) begin
                  per3_q <= per3_q + 1'b1;
               end else begin
                  per3_q  <= '0;
                  iter3_q <= iter3_q + 1'b1;
               end
               skip_q <= 1'b0;
            end
            default: begin
               // Last address was just accepted
               valid_o <= 1'b0;
               done_o  <= 1'b1;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/databus_burst_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module databus_burst_ctrl (
   input  wire                       clk_i,
   input  wire                       rst_i,
   input  wire                       run_i,
   input  addr_types_pkg::count_t    count_i,
   input  addr_types_pkg::axi_addr_t start_address_i,
   input  addr_types_pkg::axi_addr_t address_shift_i,
   input  addr_types_pkg::len_t      databus_length_i,
   input  wire                       data_ready_i,
   input  wire                       data_valid_i,
   input  wire                       reading_i,
   output logic                      data_last_o,
   input  wire                       databus_ready_i,
   output logic                      databus_valid_o,
   output addr_types_pkg::axi_addr_t databus_addr_o,
   output addr_types_pkg::len_t      databus_len_o,
   input  wire                       databus_last_i,
   output logic                      idle_o
);
   import addr_types_pkg::*;
   import addr_ctrl_pkg::*;

   bus_state_e state_q;
   axi_addr_t  addr_q;
   logic       valid_q;
   logic       final_q;
   logic       count_is_zero;
   logic       burst_end;

   count_n_loops u_count (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .start_i         (run_i),
      .count_i         (count_i),
      .advance_i       (burst_end),
      .count_is_zero_o (count_is_zero)
   );

   // Reads wait on the data side having room
   assign databus_valid_o = reading_i ? (valid_q && data_ready_i) : data_valid_i;

   assign burst_end = (state_q == BUS_BURST) && databus_valid_o && databus_ready_i &&
                      databus_last_i;

   assign data_last_o    = burst_end && count_is_zero;
   assign databus_addr_o = addr_q;
   assign databus_len_o  = databus_length_i;
   assign idle_o         = (state_q == BUS_IDLE);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= BUS_IDLE;
         addr_q  <= '0;
         valid_q <= 1'b0;
         final_q <= 1'b0;
      end else begin
         case (state_q)
            BUS_IDLE: begin
               if (run_i && (count_i != '0) && (databus_length_i != '0)) begin
                  state_q <= BUS_SETUP;
                  addr_q  <= start_address_i;
                  final_q <= 1'b0;
               end
            end
            BUS_SETUP: begin
               // final_q marks that the last burst has already gone out
               if (final_q) begin
                  state_q <= BUS_IDLE;
               end else begin
                  state_q <= BUS_BURST;
                  valid_q <= 1'b1;
               end
            end
            BUS_BURST: begin
               if (burst_end) begin
                  state_q <= BUS_SETUP;
                  valid_q <= 1'b0;
                  addr_q  <= addr_q + address_shift_i;
                  final_q <= count_is_zero;
               end
            end
            default: begin
               state_q <= BUS_IDLE;
               valid_q <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/addr_gen_top.sv
`timescale 1ns/10ps
`default_nettype none

module addr_gen_top (
   input  wire                                      clk_i,
   input  wire                                      rst_i,
   input  wire                                      run_i,
   input  wire                                      ignore_first_i,
   input  addr_types_pkg::addr_t                    start_i,
   input  addr_types_pkg::period_t                  duty_i,
   input  wire [addr_types_pkg::DELAY_W-1:0]        delay_i,
   input  addr_types_pkg::period_t                  period_i,
   input  addr_types_pkg::step_t                    incr_i,
   input  addr_types_pkg::addr_t                    iterations_i,
   input  addr_types_pkg::step_t                    shift_i,
   input  addr_types_pkg::period_t                  period2_i,
   input  addr_types_pkg::step_t                    incr2_i,
   input  addr_types_pkg::addr_t                    iterations2_i,
   input  addr_types_pkg::step_t                    shift2_i,
   input  addr_types_pkg::period_t                  period3_i,
   input  addr_types_pkg::step_t                    incr3_i,
   input  addr_types_pkg::addr_t                    iterations3_i,
   input  addr_types_pkg::step_t                    shift3_i,
   output logic                                     valid_o,
   input  wire                                      ready_i,
   output addr_types_pkg::addr_t                    addr_o,
   output logic                                     store_o,
   input  addr_types_pkg::count_t                   count_i,
   input  addr_types_pkg::axi_addr_t                start_address_i,
   input  addr_types_pkg::axi_addr_t                address_shift_i,
   input  addr_types_pkg::len_t                     databus_length_i,
   input  wire                                      data_ready_i,
   input  wire                                      data_valid_i,
   input  wire                                      reading_i,
   output logic                                     data_last_o,
   input  wire                                      databus_ready_i,
   output logic                                     databus_valid_o,
   output addr_types_pkg::axi_addr_t                databus_addr_o,
   output addr_types_pkg::len_t                     databus_len_o,
   input  wire                                      databus_last_i,
   output logic                                     done_o
);

   logic done_address;
   logic bus_idle;

   loop_cfg_if cfg_if ();

   // Memory side configuration
   assign cfg_if.start       = start_i;
   assign cfg_if.duty        = duty_i;
   assign cfg_if.delay       = delay_i;
   assign cfg_if.period      = period_i;
   assign cfg_if.incr        = incr_i;
   assign cfg_if.iterations  = iterations_i;
   assign cfg_if.shift       = shift_i;
   assign cfg_if.period2     = period2_i;
   assign cfg_if.incr2       = incr2_i;
   assign cfg_if.iterations2 = iterations2_i;
   assign cfg_if.shift2      = shift2_i;
   assign cfg_if.period3     = period3_i;
   assign cfg_if.incr3       = incr3_i;
   assign cfg_if.iterations3 = iterations3_i;
   assign cfg_if.shift3      = shift3_i;

   loop_addr_gen u_loop (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .run_i          (run_i),
      .ignore_first_i (ignore_first_i),
      .cfg            (cfg_if.dst),
      .valid_o        (valid_o),
      .ready_i        (ready_i),
      .addr_o         (addr_o),
      .store_o        (store_o),
      .done_o         (done_address)
   );

   databus_burst_ctrl u_bus (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .run_i            (run_i),
      .count_i          (count_i),
      .start_address_i  (start_address_i),
      .address_shift_i  (address_shift_i),
      .databus_length_i (databus_length_i),
      .data_ready_i     (data_ready_i),
      .data_valid_i     (data_valid_i),
      .reading_i        (reading_i),
      .data_last_o      (data_last_o),
      .databus_ready_i  (databus_ready_i),
      .databus_valid_o  (databus_valid_o),
      .databus_addr_o   (databus_addr_o),
      .databus_len_o    (databus_len_o),
      .databus_last_i   (databus_last_i),
      .idle_o           (bus_idle)
   );

   // Both halves finished
   assign done_o = done_address && bus_idle;

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #50 clk_o = ~clk_o;
      end
   end

   // Reset held for the first 16 cycles
   initial begin
      rst_o = 1'b1;
      repeat (16) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

`default_nettype wire

//--- tests/addr_gen_properties.sv
`timescale 1ns/10ps
`default_nettype none

module addr_gen_properties (
   input wire                              clk_i,
   input wire                              rst_i,
   input wire                              valid_o,
   input wire                              ready_i,
   input addr_types_pkg::addr_t            addr_o,
   input wire                              done_o,
   input wire                              databus_valid_o,
   input wire                              databus_ready_i,
   input addr_types_pkg::axi_addr_t        databus_addr_o
);

   // Stalled memory address must hold
   addr_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
      (valid_o && !ready_i) |=> $stable(addr_o))
      else $error("addr_o moved while stalled");

   done_no_valid_a : assert property (@(posedge clk_i) disable iff (rst_i)
      done_o |-> !valid_o)
      else $error("valid_o high while done_o high");

   // Burst address frozen under back-pressure
   bus_addr_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
      (databus_valid_o && !databus_ready_i) |=> $stable(databus_addr_o))
      else $error("databus_addr_o moved while stalled");

endmodule

bind addr_gen_top addr_gen_properties props0 (.*);

`default_nettype wire

//--- tests/tb_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_addr_gen;
   import addr_types_pkg::*;

   logic clk_i;
   logic rst_i;
   logic run_i, ignore_first_i, ready_i, valid_o, store_o, done_o;
   addr_t start_i, addr_o;
   period_t duty_i, period_i, period2_i, period3_i;
   logic [DELAY_W-1:0] delay_i;
   step_t incr_i, incr2_i, incr3_i, shift_i, shift2_i, shift3_i;
   addr_t iterations_i, iterations2_i, iterations3_i;
   count_t count_i;
   axi_addr_t start_address_i, address_shift_i, databus_addr_o;
   len_t databus_length_i, databus_len_o;
   logic data_ready_i, data_valid_i, reading_i, data_last_o;
   logic databus_ready_i, databus_valid_o, databus_last_i;

   int cfg_mem [0:15][0:21];
   int n_cfg;
   int cycles;
   int cycle_limit;
   addr_t exp_addr [$];
   logic exp_store [$];

   tb_clock_gen clk_gen0 (.clk_o(clk_i), .rst_o(rst_i));

   addr_gen_top dut0 (.*);

   task automatic fail_run();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check_addr(input addr_t got, input addr_t exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
         fail_run();
      end
   endtask

   task automatic check_bus_addr(input axi_addr_t got, input axi_addr_t exp,
                                 input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
         fail_run();
      end
   endtask

   task automatic check_len(input len_t got, input len_t exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
         fail_run();
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
         fail_run();
      end
   endtask

   function automatic addr_t scaled(input int s);
      return addr_t'(step_t'(s)) << OFFSET_W;
   endfunction

   function automatic int lim(input int x);
      return (x == 0) ? 1 : x;
   endfunction

   // Expected address and store stream from the nested loop rules
   task automatic build_model(input int li);
      addr_t a, b2, b3;
      logic sk, st, st_prev;
      exp_addr.delete();
      exp_store.delete();
      a = addr_t'(cfg_mem[li][1]) << OFFSET_W;
      b2 = a;
      b3 = a;
      sk = cfg_mem[li][0] != 0;
      st_prev = 1'b0;
      for (int i3 = 0; i3 < lim(cfg_mem[li][14]); i3++)
      for (int p3 = 0; p3 < lim(cfg_mem[li][12]); p3++)
      for (int i2 = 0; i2 < lim(cfg_mem[li][10]); i2++)
      for (int p2 = 0; p2 < lim(cfg_mem[li][8]); p2++)
      for (int i1 = 0; i1 < lim(cfg_mem[li][6]); i1++)
      for (int p1 = 0; p1 < lim(cfg_mem[li][4]); p1++) begin
         if (p1 != 0) begin
            if (st_prev) a = a + scaled(cfg_mem[li][5]);
         end else if (i1 != 0) begin
            if (!sk) a = a + scaled(cfg_mem[li][7]);
            sk = 1'b0;
         end else if (p2 != 0 || i2 != 0) begin
            if (!sk) begin
               b2 = b2 + scaled((p2 != 0) ? cfg_mem[li][9] : cfg_mem[li][11]);
               a = b2;
            end
            sk = 1'b0;
         end else if (p3 != 0 || i3 != 0) begin
            if (!sk) begin
               b3 = b3 + scaled((p3 != 0) ? cfg_mem[li][13] : cfg_mem[li][15]);
               b2 = b3;
               a = b3;
            end
            sk = 1'b0;
         end
         st = (p1 < cfg_mem[li][2]) && !sk;
         exp_addr.push_back(a);
         exp_store.push_back(st);
         st_prev = st;
      end
   endtask

   // Starts on the first falling edge after the load edge
   task automatic mem_side(input int li);
      int k;
      int idx;
      k = 0;
      idx = 0;
      check_flag(done_o, 1'b0, "done_o after run");
      forever begin
         check_flag(valid_o, k >= cfg_mem[li][3], "valid_o during delay");
         if (k >= cfg_mem[li][3]) break;
         k++;
         @(negedge clk_i);
      end
      while (idx < exp_addr.size()) begin
         check_flag(valid_o, 1'b1, "valid_o");
         check_flag(done_o, 1'b0, "done_o while addresses remain");
         check_addr(addr_o, exp_addr[idx], "addr_o");
         check_flag(store_o, exp_store[idx], "store_o");
         ready_i = ($urandom() % 4) != 0;
         if (ready_i) idx++;
         @(negedge clk_i);
      end
      ready_i = 1'b0;
      check_flag(valid_o, 1'b0, "valid_o after last");
   endtask

   task automatic bus_side(input int li);
      int beat;
      logic hs;
      logic exp_valid;
      if (cfg_mem[li][16] == 0 || cfg_mem[li][19] == 0) return;
      @(negedge clk_i);
      for (int k = 0; k < cfg_mem[li][16]; k++) begin
         beat = 0;
         while (beat < cfg_mem[li][19]) begin
            check_bus_addr(databus_addr_o, start_address_i + axi_addr_t'(k) * address_shift_i,
                           "databus_addr_o");
            check_len(databus_len_o, len_t'(cfg_mem[li][19]), "databus_len_o");
            check_flag(done_o, 1'b0, "done_o during burst");
            databus_ready_i = ($urandom() % 4) != 0;
            data_ready_i = ($urandom() % 4) != 0;
            data_valid_i = ($urandom() % 4) != 0;
            databus_last_i = (beat == cfg_mem[li][19] - 1);
            #10;
            exp_valid = reading_i ? data_ready_i : data_valid_i;
            check_flag(databus_valid_o, exp_valid, "databus_valid_o");
            hs = exp_valid && databus_ready_i;
            check_flag(data_last_o, hs && databus_last_i && (k == cfg_mem[li][16] - 1),
                       "data_last_o");
            if (hs) beat++;
            @(negedge clk_i);
         end
         // Valid stays low in the setup cycle between bursts
         databus_ready_i = 1'b0;
         data_ready_i = 1'b1;
         data_valid_i = 1'b0;
         databus_last_i = 1'b0;
         #10;
         check_flag(databus_valid_o, 1'b0, "databus_valid_o in setup");
         check_flag(done_o, 1'b0, "done_o in setup");
         @(negedge clk_i);
      end
   endtask

   task automatic read_stim();
      int fd;
      int r;
      string line;
      fd = $fopen("tests/addr_gen_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file");
         fail_run();
      end
      n_cfg = 0;
      while (!$feof(fd)) begin
         line = "";
         r = $fgets(line, fd);
         if (r > 1 && line[0] != "#") begin
            r = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
               cfg_mem[n_cfg][0], cfg_mem[n_cfg][1], cfg_mem[n_cfg][2], cfg_mem[n_cfg][3],
               cfg_mem[n_cfg][4], cfg_mem[n_cfg][5], cfg_mem[n_cfg][6], cfg_mem[n_cfg][7],
               cfg_mem[n_cfg][8], cfg_mem[n_cfg][9], cfg_mem[n_cfg][10], cfg_mem[n_cfg][11],
               cfg_mem[n_cfg][12], cfg_mem[n_cfg][13], cfg_mem[n_cfg][14], cfg_mem[n_cfg][15],
               cfg_mem[n_cfg][16], cfg_mem[n_cfg][17], cfg_mem[n_cfg][18], cfg_mem[n_cfg][19],
               cfg_mem[n_cfg][20], cfg_mem[n_cfg][21]);
            if (r == 22) n_cfg++;
         end
      end
      $fclose(fd);
   endtask

   task automatic apply_cfg(input int li);
      ignore_first_i = cfg_mem[li][0] != 0;
      start_i = addr_t'(cfg_mem[li][1]);
      duty_i = period_t'(cfg_mem[li][2]);
      delay_i = (DELAY_W)'(cfg_mem[li][3]);
      period_i = period_t'(cfg_mem[li][4]);
      incr_i = step_t'(cfg_mem[li][5]);
      iterations_i = addr_t'(cfg_mem[li][6]);
      shift_i = step_t'(cfg_mem[li][7]);
      period2_i = period_t'(cfg_mem[li][8]);
      incr2_i = step_t'(cfg_mem[li][9]);
      iterations2_i = addr_t'(cfg_mem[li][10]);
      shift2_i = step_t'(cfg_mem[li][11]);
      period3_i = period_t'(cfg_mem[li][12]);
      incr3_i = step_t'(cfg_mem[li][13]);
      iterations3_i = addr_t'(cfg_mem[li][14]);
      shift3_i = step_t'(cfg_mem[li][15]);
      count_i = count_t'(cfg_mem[li][16]);
      start_address_i = axi_addr_t'(cfg_mem[li][17]);
      address_shift_i = axi_addr_t'(cfg_mem[li][18]);
      databus_length_i = len_t'(cfg_mem[li][19]);
      reading_i = cfg_mem[li][20] != 0;
   endtask

   // Run limit
   always @(posedge clk_i) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: the run took more than %0d cycles", cycle_limit);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   end

   initial begin
      run_i = 1'b0;
      ignore_first_i = 1'b0;
      ready_i = 1'b0;
      start_i = '0;
      duty_i = '0;
      delay_i = '0;
      period_i = '0;
      period2_i = '0;
      period3_i = '0;
      incr_i = '0;
      incr2_i = '0;
      incr3_i = '0;
      shift_i = '0;
      shift2_i = '0;
      shift3_i = '0;
      iterations_i = '0;
      iterations2_i = '0;
      iterations3_i = '0;
      count_i = '0;
      start_address_i = '0;
      address_shift_i = '0;
      databus_length_i = '0;
      data_ready_i = 1'b0;
      data_valid_i = 1'b0;
      reading_i = 1'b0;
      databus_ready_i = 1'b0;
      databus_last_i = 1'b0;
      cycles = 0;
      cycle_limit = 0;
      void'($urandom(47753));
      read_stim();
      cycle_limit = 200;
      for (int i = 0; i < n_cfg; i++) begin
         cycle_limit += cfg_mem[i][21] * 4 + cfg_mem[i][3];
      end
      @(negedge rst_i);
      for (int i = 0; i < n_cfg; i++) begin
         build_model(i);
         if (exp_addr.size() != cfg_mem[i][21]) begin
            $display("Item count %0d of line %0d differs from the file", exp_addr.size(), i);
            fail_run();
         end
         @(negedge clk_i);
         check_flag(done_o, 1'b1, "done_o before run");
         apply_cfg(i);
         run_i = 1'b1;
         @(negedge clk_i);
         run_i = 1'b0;
         fork
            mem_side(i);
            bus_side(i);
         join
         @(negedge clk_i);
         check_flag(done_o, 1'b1, "done_o at end");
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/addr_gen_stim.txt
# ign start duty delay | per incr it shift | per2 incr2 it2 shift2 | per3 incr3 it3 shift3
# | count start_address address_shift len reading | expected item count
0 4 3 0 5 1 3 2 0 0 0 0 0 0 0 0 3 4096 64 4 1 15
0 0 2 2 2 1 2 3 2 8 2 16 2 64 1 0 2 8192 256 3 0 32
0 200 4 5 4 -1 2 10 0 0 0 0 0 0 0 0 1 1024 0 2 1 8
1 16 2 1 3 1 3 4 2 20 1 0 0 0 0 0 0 0 0 4 0 18

//--- verilog.f
hw/addr_types_pkg.sv
hw/addr_ctrl_pkg.sv
hw/loop_cfg_if.sv
hw/count_n_loops.sv
hw/loop_addr_gen.sv
hw/databus_burst_ctrl.sv
hw/addr_gen_top.sv
tests/tb_clock_gen.sv
tests/addr_gen_properties.sv
tests/tb_addr_gen.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the address generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_addr_gen -o sim_addr_gen

./obj_dir/sim_addr_gen > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi
exit 0
